//--- build.f
verilog/mdu_pkg.sv
verilog/mdu_unit_if.sv
verilog/mdu_multiplier.sv
verilog/mdu_divider.sv
verilog/mdu_control.sv
verilog/mdu_top.sv
tests/mdu_tb.sv

//--- tests/mdu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mdu_tb;
	import mdu_pkg::*;

	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic reset;
	logic cmd_valid;
	mdu_op_e cmd_op;
	logic [DATA_W-1:0] cmd_a;
	logic [DATA_W-1:0] cmd_b;
	logic cmd_ready;
	logic rsp_valid;
	logic rsp_ready;
	logic [DATA_W-1:0] rsp_data;
	logic busy;

	integer seed;
	// Reference copy of HI/LO
	logic [DATA_W-1:0] model_hi;
	logic [DATA_W-1:0] model_lo;
	logic [DATA_W-1:0] corners [5];

	mdu_top mdu_top_i (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.cmd_a(cmd_a),
		.cmd_b(cmd_b),
		.cmd_ready(cmd_ready),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp_data(rsp_data),
		.busy(busy)
	);

	always #50 clk = ~clk;

	////////////////////////////////////////
	// Handshake helpers
	////////////////////////////////////////

	task automatic check_eq(input string name, input logic [DATA_W-1:0] expected,
		input logic [DATA_W-1:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected %08h actual %08h", name, expected, actual);
			$display("sim failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("sim failed");
		$fatal(1, "wait timeout");
	endtask

	task automatic send_cmd(input mdu_op_e op, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b);
		int cycles;
		cycles = 0;
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd_op <= op;
		cmd_a <= a;
		cmd_b <= b;
		// Transfer happens on the edge after cmd_ready is seen
		@(negedge clk);
		while (!cmd_ready) begin
			cycles = cycles + 1;
			if (cycles > WAIT_LIMIT) report_timeout("cmd_ready");
			@(negedge clk);
		end
		@(posedge clk);
		cmd_valid <= 1'b0;
	endtask

	task automatic wait_rsp(output logic [DATA_W-1:0] data);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!rsp_valid) begin
			cycles = cycles + 1;
			if (cycles > WAIT_LIMIT) report_timeout("rsp_valid");
			@(negedge clk);
		end
		data = rsp_data;
	endtask

	task automatic read_reg(input mdu_op_e op, output logic [DATA_W-1:0] data);
		send_cmd(op, '0, '0);
		wait_rsp(data);
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!cmd_ready || busy) begin
			cycles = cycles + 1;
			if (cycles > WAIT_LIMIT) report_timeout("the unit to finish");
			@(negedge clk);
		end
	endtask

	task automatic check_regs(input string name);
		logic [DATA_W-1:0] d;
		read_reg(OP_MFHI, d);
		check_eq({name, " hi"}, model_hi, d);
		read_reg(OP_MFLO, d);
		check_eq({name, " lo"}, model_lo, d);
	endtask

	// Busy and no new commands while a unit runs
	task automatic check_running(input string name);
		@(negedge clk);
		check_eq({name, " busy"}, 1'b1, busy);
		check_eq({name, " cmd_ready"}, 1'b0, cmd_ready);
	endtask

	////////////////////////////////////////
	// Arithmetic with the reference model
	////////////////////////////////////////

	task automatic run_mult(input string name, input mdu_op_e op,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		logic [2*DATA_W-1:0] prod;
		if (op == OP_MULT) begin
			prod = {{DATA_W{a[DATA_W-1]}}, a} * {{DATA_W{b[DATA_W-1]}}, b};
		end else begin
			prod = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};
		end
		model_hi = prod[2*DATA_W-1:DATA_W];
		model_lo = prod[DATA_W-1:0];
		send_cmd(op, a, b);
		check_running(name);
		wait_idle();
		check_regs(name);
	endtask

	task automatic run_div(input string name, input mdu_op_e op,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		logic signed [2*DATA_W-1:0] sa;
		logic signed [2*DATA_W-1:0] sb;
		logic signed [2*DATA_W-1:0] q;
		logic signed [2*DATA_W-1:0] r;
		// Zero divisor leaves the model untouched
		if (b != '0) begin
			if (op == OP_DIV) begin
				sa = {{DATA_W{a[DATA_W-1]}}, a};
				sb = {{DATA_W{b[DATA_W-1]}}, b};
			end else begin
				sa = {{DATA_W{1'b0}}, a};
				sb = {{DATA_W{1'b0}}, b};
			end
			// 64-bit math so min / -1 wraps only when truncated
			q = sa / sb;
			r = sa % sb;
			model_lo = q[DATA_W-1:0];
			model_hi = r[DATA_W-1:0];
		end
		send_cmd(op, a, b);
		check_running(name);
		wait_idle();
		check_regs(name);
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic test_moves();
		logic [DATA_W-1:0] d;
		read_reg(OP_MFHI, d);
		check_eq("reset hi", '0, d);
		read_reg(OP_MFLO, d);
		check_eq("reset lo", '0, d);
		model_hi = $random(seed);
		model_lo = $random(seed);
		send_cmd(OP_MTHI, model_hi, '0);
		send_cmd(OP_MTLO, model_lo, '0);
		check_regs("move-to");
	endtask

	task automatic test_mult();
		int i;
		int j;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		for (i = 0; i < 5; i++) begin
			for (j = 0; j < 5; j++) begin
				run_mult("mult corner", OP_MULT, corners[i], corners[j]);
				run_mult("multu corner", OP_MULTU, corners[i], corners[j]);
			end
		end
		repeat (20) begin
			a = $random(seed);
			b = $random(seed);
			run_mult("mult random", OP_MULT, a, b);
			run_mult("multu random", OP_MULTU, a, b);
		end
	endtask

	task automatic test_div();
		int i;
		int j;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] d;
		for (i = 0; i < 5; i++) begin
			for (j = 0; j < 5; j++) begin
				if (corners[j] != '0) begin
					run_div("div corner", OP_DIV, corners[i], corners[j]);
					run_div("divu corner", OP_DIVU, corners[i], corners[j]);
				end
			end
		end
		repeat (20) begin
			a = $random(seed);
			b = $random(seed);
			if (b == '0) b = 1;
			run_div("div random", OP_DIV, a, b);
			run_div("divu random", OP_DIVU, a, b);
		end
		// Most negative over minus one wraps
		run_div("div overflow", OP_DIV, 32'h8000_0000, 32'hffff_ffff);
		read_reg(OP_MFLO, d);
		check_eq("div overflow quotient", 32'h8000_0000, d);
		read_reg(OP_MFHI, d);
		check_eq("div overflow remainder", '0, d);
	endtask

	task automatic test_div_zero();
		model_hi = 32'h1234_5678;
		model_lo = 32'h9abc_def0;
		send_cmd(OP_MTHI, model_hi, '0);
		send_cmd(OP_MTLO, model_lo, '0);
		run_div("div by zero", OP_DIV, 32'h0000_0055, '0);
		run_div("divu by zero", OP_DIVU, 32'hffff_fff0, '0);
	endtask

	task automatic test_backpressure();
		logic [DATA_W-1:0] held;
		@(posedge clk);
		rsp_ready <= 1'b0;
		read_reg(OP_MFLO, held);
		check_eq("backpressure data", model_lo, held);
		repeat (6) begin
			@(negedge clk);
			check_eq("backpressure rsp_valid", 1'b1, rsp_valid);
			check_eq("backpressure rsp_data", model_lo, rsp_data);
			check_eq("backpressure cmd_ready", 1'b0, cmd_ready);
		end
		@(posedge clk);
		rsp_ready <= 1'b1;
		// Move-to right after the take
		model_hi = $random(seed);
		send_cmd(OP_MTHI, model_hi, '0);
		check_regs("after backpressure");
	endtask

	initial begin
		seed = 41372;
		clk = 1'b0;
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_op = OP_MFHI;
		cmd_a = '0;
		cmd_b = '0;
		rsp_ready = 1'b1;
		model_hi = '0;
		model_lo = '0;
		corners[0] = 32'h0000_0000;
		corners[1] = 32'h0000_0001;
		corners[2] = 32'hffff_ffff;
		corners[3] = 32'h8000_0000;
		corners[4] = 32'h7fff_ffff;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		test_moves();
		test_mult();
		test_div();
		test_div_zero();
		test_backpressure();

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/mdu_top.sv
`timescale 1ns/1ns
`default_nettype none

module mdu_top (
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	input mdu_pkg::mdu_op_e cmd_op,
	input logic [mdu_pkg::DATA_W-1:0] cmd_a,
	input logic [mdu_pkg::DATA_W-1:0] cmd_b,
	output logic cmd_ready,
	output logic rsp_valid,
	input logic rsp_ready,
	output logic [mdu_pkg::DATA_W-1:0] rsp_data,
	output logic busy
);

	// One link per arithmetic unit
	mdu_unit_if mul_if ();
	mdu_unit_if div_if ();

	mdu_control control_i (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.cmd_a(cmd_a),
		.cmd_b(cmd_b),
		.cmd_ready(cmd_ready),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp_data(rsp_data),
		.busy(busy),
		.mul(mul_if.ctrl),
		.div(div_if.ctrl)
	);

	mdu_multiplier multiplier_i (
		.clk(clk),
		.reset(reset),
		.port(mul_if.unit)
	);

	mdu_divider divider_i (
		.clk(clk),
		.reset(reset),
		.port(div_if.unit)
	);

endmodule

`default_nettype wire

//--- verilog/mdu_control.sv
`timescale 1ns/1ns
`default_nettype none

module mdu_control (
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	input mdu_pkg::mdu_op_e cmd_op,
	input logic [mdu_pkg::DATA_W-1:0] cmd_a,
	input logic [mdu_pkg::DATA_W-1:0] cmd_b,
	output logic cmd_ready,
	output logic rsp_valid,
	input logic rsp_ready,
	output logic [mdu_pkg::DATA_W-1:0] rsp_data,
	output logic busy,
	mdu_unit_if.ctrl mul,
	mdu_unit_if.ctrl div
);
	import mdu_pkg::*;

	ctrl_state_e state;
	logic accept;
	logic mul_cmd;
	logic div_cmd;
	logic mul_start;
	logic div_start;
	logic op_signed;
	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	logic [DATA_W-1:0] hi;
	logic [DATA_W-1:0] lo;

	assign accept = cmd_valid && cmd_ready;
	assign mul_cmd = (cmd_op == OP_MULT) || (cmd_op == OP_MULTU);
	assign div_cmd = (cmd_op == OP_DIV) || (cmd_op == OP_DIVU);

	assign cmd_ready = (state == IDLE);
	assign rsp_valid = (state == RSP_HOLD);
	assign busy = (state == MUL_WAIT) || (state == DIV_WAIT);

	// Both units see the same latched operands
	assign mul.start = mul_start;
	assign mul.is_signed = op_signed;
	assign mul.a = op_a;
	assign mul.b = op_b;
	assign div.start = div_start;
	assign div.is_signed = op_signed;
	assign div.a = op_a;
	assign div.b = op_b;

	////////////////////////////////////////
	// FSM and HI/LO
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			mul_start <= 1'b0;
			div_start <= 1'b0;
			hi <= '0;
			lo <= '0;
		end else begin
			// Start goes out the cycle after accept
			mul_start <= accept && mul_cmd;
			div_start <= accept && div_cmd;
			case (state)
				IDLE: begin
					if (accept) begin
						case (cmd_op)
							OP_MTHI: hi <= cmd_a;
							OP_MTLO: lo <= cmd_a;
							OP_MFHI, OP_MFLO: state <= RSP_HOLD;
							OP_MULT, OP_MULTU: state <= MUL_WAIT;
							OP_DIV, OP_DIVU: state <= DIV_WAIT;
						endcase
					end
				end
				MUL_WAIT: begin
					if (mul.done) begin
						hi <= mul.hi;
						lo <= mul.lo;
						state <= IDLE;
					end
				end
				DIV_WAIT: begin
					if (div.done) begin
						// Zero divisor keeps the old HI/LO
						if (!div.skip) begin
							hi <= div.hi;
							lo <= div.lo;
						end
						state <= IDLE;
					end
				end
				RSP_HOLD: begin
					if (rsp_ready) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Operands and response data
	always_ff @(posedge clk) begin
		if (accept) begin
			op_a <= cmd_a;
			op_b <= cmd_b;
			op_signed <= (cmd_op == OP_MULT) || (cmd_op == OP_DIV);
			if (cmd_op == OP_MFHI) begin
				rsp_data <= hi;
			end else if (cmd_op == OP_MFLO) begin
				rsp_data <= lo;
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset) mul.start |-> !mul.busy);
	assert property (@(posedge clk) disable iff (reset) div.start |-> !div.busy);

	// Held response must not move under back-pressure
	assert property (@(posedge clk) disable iff (reset)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data));

endmodule

`default_nettype wire

//--- verilog/mdu_divider.sv
`timescale 1ns/1ns
`default_nettype none

module mdu_divider (
	input logic clk,
	input logic reset,
	mdu_unit_if.unit port
);
	import mdu_pkg::*;

	logic running;
	logic zero_div;
	logic [$clog2(DIV_CYCLES)-1:0] step;
	logic fix_cycle;
	logic q_neg;
	logic r_neg;
	logic [DATA_W-1:0] a_mag;
	logic [DATA_W-1:0] b_mag;
	logic [DATA_W-1:0] divisor;
	logic [DATA_W-1:0] quo;
	logic [DATA_W-1:0] rem;
	logic [DATA_W:0] rem_shift;
	logic [DATA_W+1:0] diff;

	assign a_mag = (port.is_signed && port.a[DATA_W-1]) ? -port.a : port.a;
	assign b_mag = (port.is_signed && port.b[DATA_W-1]) ? -port.b : port.b;

	////////////////////////////////////////
	// Restoring step
	////////////////////////////////////////

	// Next dividend bit enters the partial remainder
	assign rem_shift = {rem, quo[DATA_W-1]};
	// Top bit set means the trial subtract went negative
	assign diff = {1'b0, rem_shift} - {2'b0, divisor};

	// Zero divisor finishes right away
	assign fix_cycle = running && (zero_div || step == DIV_CYCLES - 1);

	assign port.busy = running;
	assign port.done = fix_cycle;
	assign port.skip = zero_div;
	// Remainder follows the dividend sign
	assign port.hi = r_neg ? -rem : rem;
	assign port.lo = q_neg ? -quo : quo;

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			zero_div <= 1'b0;
			step <= '0;
		end else if (port.start) begin
			running <= 1'b1;
			zero_div <= (port.b == '0);
			step <= '0;
		end else if (fix_cycle) begin
			running <= 1'b0;
		end else if (running) begin
			step <= step + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (port.start) begin
			divisor <= b_mag;
			quo <= a_mag;
			rem <= '0;
			q_neg <= port.is_signed && (port.a[DATA_W-1] ^ port.b[DATA_W-1]);
			r_neg <= port.is_signed && port.a[DATA_W-1];
		end else if (running && !fix_cycle) begin
			if (diff[DATA_W+1]) begin
				rem <= rem_shift[DATA_W-1:0];
			end else begin
				rem <= diff[DATA_W-1:0];
			end
			quo <= {quo[DATA_W-2:0], ~diff[DATA_W+1]};
		end
	end

	// A new start only lands on an idle divider
	assert property (@(posedge clk) disable iff (reset)
		port.start |-> !port.busy && !port.done);

endmodule

`default_nettype wire

//--- verilog/mdu_multiplier.sv
`timescale 1ns/1ns
`default_nettype none

module mdu_multiplier (
	input logic clk,
	input logic reset,
	mdu_unit_if.unit port
);
	import mdu_pkg::*;

	logic running;
	logic [$clog2(MULT_CYCLES)-1:0] step;
	logic fix_cycle;
	logic negate;
	logic [DATA_W-1:0] mcand;
	logic [DATA_W-1:0] a_mag;
	logic [DATA_W-1:0] b_mag;
	// Upper half is the running sum, lower half the unused multiplier digits
	logic [2*DATA_W-1:0] acc;
	logic [DATA_W+MULT_DIGIT_W-1:0] upper_sum;
	logic [2*DATA_W-1:0] product;

	// Operand magnitudes
	assign a_mag = (port.is_signed && port.a[DATA_W-1]) ? -port.a : port.a;
	assign b_mag = (port.is_signed && port.b[DATA_W-1]) ? -port.b : port.b;

	// One 32x4 partial product per step
	assign upper_sum = {{MULT_DIGIT_W{1'b0}}, acc[2*DATA_W-1:DATA_W]}
		+ mcand * acc[MULT_DIGIT_W-1:0];

	// Last cycle applies the result sign
	assign fix_cycle = running && (step == MULT_CYCLES - 1);
	assign product = negate ? -acc : acc;

	assign port.busy = running;
	assign port.done = fix_cycle;
	assign port.skip = 1'b0;
	assign port.hi = product[2*DATA_W-1:DATA_W];
	assign port.lo = product[DATA_W-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			step <= '0;
		end else if (port.start) begin
			running <= 1'b1;
			step <= '0;
		end else if (fix_cycle) begin
			running <= 1'b0;
		end else if (running) begin
			step <= step + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (port.start) begin
			mcand <= a_mag;
			acc <= {{DATA_W{1'b0}}, b_mag};
			negate <= port.is_signed && (port.a[DATA_W-1] ^ port.b[DATA_W-1]);
		end else if (running && !fix_cycle) begin
			// Shift the consumed digit out, sum moves down with it
			acc <= {upper_sum, acc[DATA_W-1:MULT_DIGIT_W]};
		end
	end

	// Controller relies on a fixed latency
	assert property (@(posedge clk) disable iff (reset)
		port.start |=> !port.done [*MULT_CYCLES-1] ##1 port.done);

endmodule

`default_nettype wire

//--- verilog/mdu_unit_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mdu_unit_if;
	import mdu_pkg::*;

	// Request side
	logic start;
	logic is_signed;
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;

	// Result side, hi/lo valid with done
	logic busy;
	logic done;
	logic skip;
	logic [DATA_W-1:0] hi;
	logic [DATA_W-1:0] lo;

	modport ctrl (
		output start, is_signed, a, b,
		input busy, done, skip, hi, lo
	);

	modport unit (
		input start, is_signed, a, b,
		output busy, done, skip, hi, lo
	);

endinterface

`default_nettype wire

//--- verilog/mdu_pkg.sv
`default_nettype none

package mdu_pkg;

	////////////////////////////////////////
	// Widths and latencies
	////////////////////////////////////////

	// Operand and HI/LO width
	localparam int DATA_W = 32;

	// Multiplier bits consumed per step
	localparam int MULT_DIGIT_W = 4;

	// Start to done, eight digit steps plus sign fix
	localparam int MULT_CYCLES = 9;

	// Start to done for a nonzero divisor
	localparam int DIV_CYCLES = 33;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	// Command opcodes, move-from first
	typedef enum logic [2:0] {
		OP_MFHI,
		OP_MFLO,
		OP_MTHI,
		OP_MTLO,
		OP_MULT,
		OP_MULTU,
		OP_DIV,
		OP_DIVU
	} mdu_op_e;

	// Controller states
	typedef enum logic [1:0] {
		IDLE,
		MUL_WAIT,
		DIV_WAIT,
		RSP_HOLD
	} ctrl_state_e;

endpackage

`default_nettype wire
